/* rtl/decode_pkg.sv */
package decode_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [7:0]      ctrl_t;
    typedef logic [3:0]      exc_t;
    typedef logic [2:0]      cmp_t;

    // control bit positions, regwrite is the msb
    localparam int CTRL_REGWRITE = 7;
    localparam int CTRL_MEMTOREG = 6;
    localparam int CTRL_MEMWRITE = 5;
    localparam int CTRL_MEMREAD  = 4;
    localparam int CTRL_BRANCH   = 3;
    localparam int CTRL_JUMP     = 2;
    localparam int CTRL_OP_IMM   = 1;
    localparam int CTRL_OP_PCIMM = 0;

    localparam int EXC_ILLEGAL = 0;
    localparam int EXC_ECALL   = 1;
    localparam int EXC_EBREAK  = 2;
    localparam int EXC_MRET    = 3;

    localparam int CMP_LT  = 2;
    localparam int CMP_LTU = 1;
    localparam int CMP_EQ  = 0;

    typedef enum logic [1:0] {
        UNIT_ALU    = 2'd0,
        UNIT_MEM    = 2'd1,
        UNIT_BRANCH = 2'd2,
        UNIT_SYSTEM = 2'd3
    } unit_t;

    typedef enum logic [4:0] {
        UOP_NOP,
        UOP_ADD, UOP_SUB, UOP_SLT, UOP_SLTU, UOP_XOR,
        UOP_OR, UOP_AND, UOP_SLL, UOP_SRL, UOP_SRA,
        UOP_LB, UOP_LH, UOP_LW, UOP_LBU, UOP_LHU,
        UOP_SB, UOP_SH, UOP_SW,
        UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU,
        UOP_JAL, UOP_JALR
    } uop_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_WB   = 2'd1,
        FWD_EX   = 2'd2
    } fwd_sel_t;

    localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

/* rtl/decode_if.sv */
`timescale 1ns/1ps

interface decode_if;
    import decode_pkg::*;

    unit_t     unit;
    uop_t      uop;
    ctrl_t     ctrl;
    exc_t      exc;
    word_t     imm;
    reg_addr_t rd;

    // inst_decoder and imm_gen share this side, each drives its own fields
    modport decoder (
        output unit, uop, ctrl, exc, imm, rd
    );

    modport sel (
        input ctrl, imm
    );

    modport stage (
        input unit, uop, ctrl, exc, imm, rd
    );

endinterface

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input decode_pkg::inst_t inst_i,
    decode_if.decoder        dec
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       known_opc;
    logic       bad_shift;
    logic       illegal;
    logic       sys_plain;
    unit_t      unit_d;
    uop_t       uop_d;
    ctrl_t      ctrl_d;
    exc_t       exc_d;

    // alt is inst[30], only splits add/sub for register ops
    function automatic uop_t alu_uop(logic [2:0] f3, logic alt, logic is_reg);
        case (f3)
            3'b000: return (is_reg && alt) ? UOP_SUB : UOP_ADD;
            3'b001: return UOP_SLL;
            3'b010: return UOP_SLT;
            3'b011: return UOP_SLTU;
            3'b100: return UOP_XOR;
            3'b101: return alt ? UOP_SRA : UOP_SRL;
            3'b110: return UOP_OR;
            default: return UOP_AND;
        endcase
    endfunction

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];

    always_comb begin
        known_opc = 1'b1;
        unit_d    = UNIT_ALU;
        uop_d     = UOP_NOP;
        ctrl_d    = '0;
        case (opcode)
            OPC_RTYPE: begin
                uop_d = alu_uop(funct3, inst_i[30], 1'b1);
                ctrl_d[CTRL_REGWRITE] = 1'b1;
            end
            OPC_ITYPE: begin
                uop_d = alu_uop(funct3, inst_i[30], 1'b0);
                ctrl_d[CTRL_REGWRITE] = 1'b1;
                ctrl_d[CTRL_OP_IMM]   = 1'b1;
            end
            OPC_LOAD: begin
                unit_d = UNIT_MEM;
                case (funct3)
                    3'b000:  uop_d = UOP_LB;
                    3'b001:  uop_d = UOP_LH;
                    3'b010:  uop_d = UOP_LW;
                    3'b100:  uop_d = UOP_LBU;
                    3'b101:  uop_d = UOP_LHU;
                    default: uop_d = UOP_NOP;
                endcase
                ctrl_d[CTRL_REGWRITE] = 1'b1;
                ctrl_d[CTRL_MEMTOREG] = 1'b1;
                ctrl_d[CTRL_MEMREAD]  = 1'b1;
                ctrl_d[CTRL_OP_IMM]   = 1'b1;
            end
            OPC_STORE: begin
                unit_d = UNIT_MEM;
                case (funct3)
                    3'b000:  uop_d = UOP_SB;
                    3'b001:  uop_d = UOP_SH;
                    3'b010:  uop_d = UOP_SW;
                    default: uop_d = UOP_NOP;
                endcase
                ctrl_d[CTRL_MEMWRITE] = 1'b1;
                ctrl_d[CTRL_OP_IMM]   = 1'b1;
            end
            OPC_BRANCH: begin
                unit_d = UNIT_BRANCH;
                case (funct3)
                    3'b000:  uop_d = UOP_BEQ;
                    3'b001:  uop_d = UOP_BNE;
                    3'b100:  uop_d = UOP_BLT;
                    3'b101:  uop_d = UOP_BGE;
                    3'b110:  uop_d = UOP_BLTU;
                    3'b111:  uop_d = UOP_BGEU;
                    default: uop_d = UOP_NOP; // 010/011 unused
                endcase
                ctrl_d[CTRL_BRANCH]   = 1'b1;
                ctrl_d[CTRL_OP_PCIMM] = 1'b1;
            end
            OPC_JAL: begin
                unit_d = UNIT_BRANCH;
                uop_d  = UOP_JAL;
                ctrl_d[CTRL_REGWRITE] = 1'b1;
                ctrl_d[CTRL_JUMP]     = 1'b1;
            end
            OPC_JALR: begin
                unit_d = UNIT_BRANCH;
                uop_d  = UOP_JALR;
                ctrl_d[CTRL_REGWRITE] = 1'b1;
                ctrl_d[CTRL_JUMP]     = 1'b1;
                ctrl_d[CTRL_OP_PCIMM] = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                uop_d = UOP_ADD; // lui adds imm to zero later on
                ctrl_d[CTRL_REGWRITE] = 1'b1;
            end
            OPC_SYSTEM: begin
                unit_d = UNIT_SYSTEM;
                ctrl_d[CTRL_REGWRITE] = 1'b1;
                ctrl_d[CTRL_OP_IMM]   = 1'b1;
            end
            default: known_opc = 1'b0;
        endcase
    end

    assign bad_shift = (opcode == OPC_ITYPE) && (funct3 == 3'b001 || funct3 == 3'b101)
                       && inst_i[25];
    assign illegal   = !known_opc || bad_shift;
    assign sys_plain = (opcode == OPC_SYSTEM) && (funct3 == 3'b000); // not a csr access

    always_comb begin
        exc_d              = '0;
        exc_d[EXC_ILLEGAL] = illegal;
        exc_d[EXC_ECALL]   = sys_plain && (inst_i[21:20] == 2'b00);
        exc_d[EXC_EBREAK]  = sys_plain && (inst_i[21:20] == 2'b01);
        exc_d[EXC_MRET]    = sys_plain && (inst_i[21:20] == 2'b10);
    end

    assign dec.unit = unit_d;
    assign dec.uop  = illegal ? UOP_NOP : uop_d;
    assign dec.ctrl = illegal ? ctrl_t'('0) : ctrl_d;
    assign dec.exc  = exc_d;
    assign dec.rd   = inst_i[11:7];

endmodule

/* rtl/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen (
    input decode_pkg::inst_t inst_i,
    decode_if.decoder        dec
);
    import decode_pkg::*;

    logic [6:0] opcode;
    word_t      imm;

    assign opcode = inst_i[6:0];

    always_comb begin
        case (opcode)
            OPC_ITYPE, OPC_LOAD, OPC_JALR, OPC_SYSTEM: begin
                imm = {{20{inst_i[31]}}, inst_i[31:20]};
            end
            OPC_STORE: begin
                imm = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            end
            OPC_BRANCH: begin
                imm = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                       inst_i[11:8], 1'b0};
            end
            OPC_JAL: begin
                imm = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                       inst_i[30:21], 1'b0};
            end
            OPC_LUI, OPC_AUIPC: imm = {inst_i[31:12], 12'h000};
            default:            imm = '0; // r-type and unknown
        endcase
    end

    assign dec.imm = imm;

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  decode_pkg::reg_addr_t rs1_addr_i,
    input  decode_pkg::reg_addr_t rs2_addr_i,
    output decode_pkg::word_t     rs1_data_o,
    output decode_pkg::word_t     rs2_data_o,
    input  decode_pkg::reg_addr_t wr_addr_i,
    input  decode_pkg::word_t     wr_data_i,
    input  logic                  wr_en_i
);
    import decode_pkg::*;

    localparam int AW = $clog2(NUM_REGS);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0 && wr_addr_i < NUM_REGS) begin
            regs[wr_addr_i[AW-1:0]] <= wr_data_i;
        end
    end

    // no bypass, same-cycle write shows up next cycle
    assign rs1_data_o = (rs1_addr_i != '0 && rs1_addr_i < NUM_REGS) ?
                        regs[rs1_addr_i[AW-1:0]] : '0;
    assign rs2_data_o = (rs2_addr_i != '0 && rs2_addr_i < NUM_REGS) ?
                        regs[rs2_addr_i[AW-1:0]] : '0;

endmodule

/* rtl/operand_select.sv */
`timescale 1ns/1ps

module operand_select (
    input  decode_pkg::word_t    rs1_data_i,
    input  decode_pkg::word_t    rs2_data_i,
    input  decode_pkg::word_t    rd_data_i,
    input  decode_pkg::word_t    ex_value_i,
    input  decode_pkg::word_t    pc_i,
    input  decode_pkg::fwd_sel_t fwd1_sel_i,
    input  decode_pkg::fwd_sel_t fwd2_sel_i,
    decode_if.sel                dec,
    output decode_pkg::word_t    value1_o,
    output decode_pkg::word_t    value2_o,
    output decode_pkg::cmp_t     cmp_o
);
    import decode_pkg::*;

    word_t op1;
    word_t op2;
    logic  use_pc;
    logic  use_imm;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t wb_val,
                                      word_t ex_val);
        case (sel)
            FWD_NONE: return reg_val;
            FWD_WB:   return wb_val;
            FWD_EX:   return ex_val;
            default:  return reg_val;
        endcase
    endfunction

    assign op1 = fwd_mux(fwd1_sel_i, rs1_data_i, rd_data_i, ex_value_i);
    assign op2 = fwd_mux(fwd2_sel_i, rs2_data_i, rd_data_i, ex_value_i);

    assign use_pc  = dec.ctrl[CTRL_BRANCH] || dec.ctrl[CTRL_OP_PCIMM];
    assign use_imm = dec.ctrl[CTRL_OP_IMM] || dec.ctrl[CTRL_OP_PCIMM];

    assign value1_o = use_pc ? pc_i : op1;
    assign value2_o = use_imm ? dec.imm : op2;

    // flags come from the register operands, branch unit needs them
    always_comb begin
        cmp_o          = '0;
        cmp_o[CMP_LT]  = $signed(op1) < $signed(op2);
        cmp_o[CMP_LTU] = op1 < op2;
        cmp_o[CMP_EQ]  = op1 == op2;
    end

endmodule

/* rtl/id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    decode_if.stage               dec,
    input  decode_pkg::word_t     pc_i,
    input  decode_pkg::word_t     value1_i,
    input  decode_pkg::word_t     value2_i,
    input  decode_pkg::cmp_t      cmp_i,
    output decode_pkg::word_t     pc_o,
    output decode_pkg::word_t     value1_o,
    output decode_pkg::word_t     value2_o,
    output decode_pkg::word_t     imm_o,
    output decode_pkg::reg_addr_t rd_addr_o,
    output decode_pkg::unit_t     unit_o,
    output decode_pkg::uop_t      uop_o,
    output decode_pkg::ctrl_t     ctrl_o,
    output decode_pkg::exc_t      exc_o,
    output decode_pkg::cmp_t      cmp_o
);
    import decode_pkg::*;

    // control fields, stall wins over flush
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            unit_o <= UNIT_ALU;
            uop_o  <= UOP_NOP;
            ctrl_o <= '0;
            exc_o  <= '0;
            cmp_o  <= '0;
        end else if (!stall_i) begin
            if (flush_i) begin
                unit_o <= UNIT_ALU; // bubble
                uop_o  <= UOP_NOP;
                ctrl_o <= '0;
                exc_o  <= '0;
                cmp_o  <= '0;
            end else begin
                unit_o <= dec.unit;
                uop_o  <= dec.uop;
                ctrl_o <= dec.ctrl;
                exc_o  <= dec.exc;
                cmp_o  <= cmp_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            pc_o      <= pc_i;
            value1_o  <= value1_i;
            value2_o  <= value2_i;
            imm_o     <= dec.imm;
            rd_addr_o <= dec.rd;
        end
    end

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage #(
    parameter int NUM_REGS = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  decode_pkg::inst_t     inst_i,
    input  decode_pkg::word_t     pc_i,
    input  decode_pkg::reg_addr_t rd_addr_i,
    input  decode_pkg::word_t     rd_data_i,
    input  logic                  rd_we_i,
    input  decode_pkg::fwd_sel_t  fwd1_sel_i,
    input  decode_pkg::fwd_sel_t  fwd2_sel_i,
    input  decode_pkg::word_t     ex_value_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    output decode_pkg::reg_addr_t rs1_addr_o,
    output decode_pkg::reg_addr_t rs2_addr_o,
    output decode_pkg::word_t     pc_o,
    output decode_pkg::word_t     value1_o,
    output decode_pkg::word_t     value2_o,
    output decode_pkg::word_t     imm_o,
    output decode_pkg::reg_addr_t rd_addr_o,
    output decode_pkg::unit_t     unit_o,
    output decode_pkg::uop_t      uop_o,
    output decode_pkg::ctrl_t     ctrl_o,
    output decode_pkg::exc_t      exc_o,
    output decode_pkg::cmp_t      cmp_o
);
    import decode_pkg::*;

    word_t rs1_data;
    word_t rs2_data;
    word_t value1;
    word_t value2;
    cmp_t  cmp;

    decode_if dec_if ();

    assign rs1_addr_o = inst_i[19:15]; // unregistered, hazard unit wants them early
    assign rs2_addr_o = inst_i[24:20];

    inst_decoder inst_decoder_i (
        .inst_i (inst_i),
        .dec    (dec_if.decoder)
    );

    imm_gen imm_gen_i (
        .inst_i (inst_i),
        .dec    (dec_if.decoder)
    );

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) reg_file_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr_o),
        .rs2_addr_i (rs2_addr_o),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_addr_i  (rd_addr_i),
        .wr_data_i  (rd_data_i),
        .wr_en_i    (rd_we_i)
    );

    operand_select operand_select_i (
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rd_data_i  (rd_data_i),
        .ex_value_i (ex_value_i),
        .pc_i       (pc_i),
        .fwd1_sel_i (fwd1_sel_i),
        .fwd2_sel_i (fwd2_sel_i),
        .dec        (dec_if.sel),
        .value1_o   (value1),
        .value2_o   (value2),
        .cmp_o      (cmp)
    );

    id_ex_reg id_ex_reg_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .stall_i   (stall_i),
        .flush_i   (flush_i),
        .dec       (dec_if.stage),
        .pc_i      (pc_i),
        .value1_i  (value1),
        .value2_i  (value2),
        .cmp_i     (cmp),
        .pc_o      (pc_o),
        .value1_o  (value1_o),
        .value2_o  (value2_o),
        .imm_o     (imm_o),
        .rd_addr_o (rd_addr_o),
        .unit_o    (unit_o),
        .uop_o     (uop_o),
        .ctrl_o    (ctrl_o),
        .exc_o     (exc_o),
        .cmp_o     (cmp_o)
    );

endmodule

/* tests/decode_properties.sv */
`timescale 1ns/1ps

module decode_properties (
    input logic                  clk_i,
    input logic                  rst_i,
    input logic                  stall_i,
    input logic                  flush_i,
    input decode_pkg::word_t     pc_o,
    input decode_pkg::word_t     value1_o,
    input decode_pkg::word_t     value2_o,
    input decode_pkg::word_t     imm_o,
    input decode_pkg::reg_addr_t rd_addr_o,
    input decode_pkg::unit_t     unit_o,
    input decode_pkg::uop_t      uop_o,
    input decode_pkg::ctrl_t     ctrl_o,
    input decode_pkg::exc_t      exc_o,
    input decode_pkg::cmp_t      cmp_o
);
    import decode_pkg::*;

    int fail_count = 0; // read by the testbench top

    reset_clears: assert property (@(posedge clk_i) rst_i |=> (ctrl_o == '0 && exc_o == '0))
        else begin
            $error("control or exception outputs active after reset");
            fail_count++;
        end

    stall_holds: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_i |=> $stable({pc_o, value1_o, value2_o, imm_o, rd_addr_o, unit_o, uop_o,
                             ctrl_o, exc_o, cmp_o}))
        else begin
            $error("outputs changed while stalled");
            fail_count++;
        end

    flush_bubble: assert property (@(posedge clk_i) disable iff (rst_i)
        (!stall_i && flush_i) |=> (uop_o == UOP_NOP && ctrl_o == '0))
        else begin
            $error("flush did not produce a bubble");
            fail_count++;
        end

    // ecall, ebreak, mret are mutually exclusive
    sys_exc_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(exc_o[EXC_MRET:EXC_ECALL]))
        else begin
            $error("more than one system exception flag set");
            fail_count++;
        end

endmodule

bind decode_stage decode_properties decode_properties_i (.*);

/* tests/decode_checker.sv */
`timescale 1ns/1ps

module decode_checker (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  logic                  exp_valid_i,
    input  logic                  exp_bubble_i,
    input  int                    exp_idx_i,
    input  logic [31:0]           exp_words_i [6],
    input  logic [31:0]           exp_inst_i,
    input  decode_pkg::reg_addr_t rs1_addr_o,
    input  decode_pkg::reg_addr_t rs2_addr_o,
    input  decode_pkg::word_t     pc_o,
    input  decode_pkg::word_t     value1_o,
    input  decode_pkg::word_t     value2_o,
    input  decode_pkg::word_t     imm_o,
    input  decode_pkg::reg_addr_t rd_addr_o,
    input  decode_pkg::unit_t     unit_o,
    input  decode_pkg::uop_t      uop_o,
    input  decode_pkg::ctrl_t     ctrl_o,
    input  decode_pkg::exc_t      exc_o,
    input  decode_pkg::cmp_t      cmp_o,
    output int                    checked_o,
    output int                    errors_o
);
    import decode_pkg::*;

    logic         stall_q;
    logic         rst_q;
    logic         pending;
    logic         bubble;
    int           idx;
    logic [31:0]  exp_w [6]; // pc, value1, value2, imm, misc, flags
    logic [31:0]  inst_w;
    logic [9:0]   rs_q; // rs1, rs2 at the launch edge
    logic [154:0] snap;
    logic         snap_ok = 1'b0;
    logic         reset_done = 1'b0;

    initial begin
        checked_o = 0;
        errors_o  = 0;
    end

    // source register fields of the base encoding
    function automatic logic [4:0] src_field(logic [31:0] word, int lsb);
        return word[lsb +: 5];
    endfunction

    function automatic int diff(string rec, string field, logic [31:0] e, logic [31:0] a);
        if (e !== a) begin
            $display("FAIL %s %s expected %08h actual %08h", rec, field, e, a);
            return 1;
        end
        return 0;
    endfunction

    always @(posedge clk_i) begin
        stall_q <= stall_i;
        rst_q   <= rst_i;
        pending <= exp_valid_i && !stall_i && !rst_i; // launch edge
        if (exp_valid_i && !stall_i) begin
            bubble <= exp_bubble_i;
            idx    <= exp_idx_i;
            exp_w  <= exp_words_i;
            inst_w <= exp_inst_i;
            rs_q   <= {rs1_addr_o, rs2_addr_o};
        end
    end

    always @(negedge clk_i) begin
        automatic string rec = $sformatf("rec_%0d", idx);
        automatic int    bad = 0;
        automatic logic [154:0] now = {pc_o, value1_o, value2_o, imm_o, rd_addr_o, unit_o,
                                       uop_o, ctrl_o, exc_o, cmp_o};
        if (rst_q && !reset_done) begin
            reset_done = 1'b1;
            if (uop_o !== UOP_NOP || ctrl_o !== '0 || exc_o !== '0 || cmp_o !== '0) begin
                $display("reset left control outputs active");
                errors_o++;
            end else begin
                $display("PASS reset");
            end
        end
        if (stall_q && !rst_q && snap_ok && now !== snap) begin
            $display("outputs changed during a stall cycle");
            errors_o++;
        end
        if (pending) begin
            bad += diff(rec, "uop", {27'd0, exp_w[4][20:16]}, {27'd0, uop_o});
            bad += diff(rec, "ctrl", {24'd0, exp_w[4][31:24]}, {24'd0, ctrl_o});
            bad += diff(rec, "exc", {28'd0, exp_w[5][3:0]}, {28'd0, exc_o});
            bad += diff(rec, "cmp", {29'd0, exp_w[5][6:4]}, {29'd0, cmp_o});
            bad += diff(rec, "rs1", {27'd0, src_field(inst_w, 15)}, {27'd0, rs_q[9:5]});
            bad += diff(rec, "rs2", {27'd0, src_field(inst_w, 20)}, {27'd0, rs_q[4:0]});
            if (!bubble) begin
                bad += diff(rec, "pc", exp_w[0], pc_o);
                bad += diff(rec, "value1", exp_w[1], value1_o);
                bad += diff(rec, "value2", exp_w[2], value2_o);
                bad += diff(rec, "imm", exp_w[3], imm_o);
                bad += diff(rec, "rd", {27'd0, exp_w[4][4:0]}, {27'd0, rd_addr_o});
                bad += diff(rec, "unit", {30'd0, exp_w[4][9:8]}, {30'd0, unit_o});
            end
            if (bad == 0) begin
                $display("PASS %s", rec);
            end
            errors_o  += bad;
            checked_o++;
        end
        snap    = now;
        snap_ok = !rst_q;
    end

endmodule

/* tests/tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage;
    import decode_pkg::*;

    localparam int REC_WORDS = 10;
    localparam int MAX_RECS  = 32;

    logic        clk_i = 1'b0;
    logic        rst_i = 1'b1;
    inst_t       inst = '0;
    word_t       pc = '0;
    reg_addr_t   wr_addr = '0;
    word_t       wr_data = '0;
    logic        wr_en = 1'b0;
    fwd_sel_t    fwd1 = FWD_NONE;
    fwd_sel_t    fwd2 = FWD_NONE;
    word_t       ex_value = '0;
    logic        stall = 1'b0;
    logic        flush = 1'b0;
    reg_addr_t   rs1_addr, rs2_addr, rd_addr;
    word_t       pc_o, value1, value2, imm;
    unit_t       unit;
    uop_t        uop;
    ctrl_t       ctrl;
    exc_t        exc;
    cmp_t        cmp;
    logic        exp_valid = 1'b0;
    logic        exp_bubble = 1'b0;
    int          exp_idx = 0;
    logic [31:0] exp_words [6] = '{default: '0};
    int          checked, errors;
    logic [31:0] golden [REC_WORDS*MAX_RECS];
    int unsigned lcg_state = 70;
    int          n_recs = 0;
    int          n_decode = 0;

    always #10 clk_i = ~clk_i;

    decode_stage #(.NUM_REGS(32)) decode_stage_i (
        .clk_i(clk_i), .rst_i(rst_i), .inst_i(inst), .pc_i(pc),
        .rd_addr_i(wr_addr), .rd_data_i(wr_data), .rd_we_i(wr_en),
        .fwd1_sel_i(fwd1), .fwd2_sel_i(fwd2), .ex_value_i(ex_value),
        .stall_i(stall), .flush_i(flush),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .pc_o(pc_o),
        .value1_o(value1), .value2_o(value2), .imm_o(imm), .rd_addr_o(rd_addr),
        .unit_o(unit), .uop_o(uop), .ctrl_o(ctrl), .exc_o(exc), .cmp_o(cmp)
    );

    decode_checker checker_i (
        .clk_i(clk_i), .rst_i(rst_i), .stall_i(stall),
        .exp_valid_i(exp_valid), .exp_bubble_i(exp_bubble), .exp_idx_i(exp_idx),
        .exp_words_i(exp_words), .exp_inst_i(inst),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .pc_o(pc_o), .value1_o(value1), .value2_o(value2), .imm_o(imm),
        .rd_addr_o(rd_addr), .unit_o(unit), .uop_o(uop), .ctrl_o(ctrl),
        .exc_o(exc), .cmp_o(cmp), .checked_o(checked), .errors_o(errors)
    );

    function automatic int unsigned lcg_next(int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic present_decode(int base);
        inst     = golden[base+1];
        pc       = golden[base+2];
        wr_data  = golden[base+3];
        ex_value = golden[base+4];
        fwd1     = fwd_sel_t'(golden[base][5:4]);
        fwd2     = fwd_sel_t'(golden[base][7:6]);
        wr_en    = 1'b0;
    endtask

    initial begin
        int base;
        int extra;
        int total_errors;
        $readmemh("tests/decode_golden.mem", golden);
        while (n_recs < MAX_RECS && (golden[n_recs*REC_WORDS][3:0] === 4'd1
               || golden[n_recs*REC_WORDS][3:0] === 4'd2)) begin
            if (golden[n_recs*REC_WORDS][3:0] === 4'd2) begin
                n_decode++;
            end
            n_recs++;
        end
        fork
            begin
                repeat (n_recs * 8 + 20) @(posedge clk_i);
                $display("timeout: run did not finish in the allowed cycles");
                $display("Result: FAILED");
                $finish;
            end
        join_none
        repeat (4) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        for (int r = 0; r < n_recs; r++) begin
            base = r * REC_WORDS;
            if (golden[base][3:0] === 4'd1) begin
                next_cycle();
                exp_valid = 1'b0;
                stall     = 1'b1; // keep outputs while loading registers
                wr_en     = 1'b1;
                wr_addr   = golden[base+1][4:0];
                wr_data   = golden[base+2];
            end else begin
                lcg_state = lcg_next(lcg_state);
                extra = (lcg_state >> 16) % 3 + (golden[base][8] ? 2 : 0);
                repeat (extra) begin
                    next_cycle();
                    exp_valid = 1'b0;
                    stall     = 1'b1;
                    present_decode(base);
                end
                next_cycle();
                present_decode(base);
                stall      = 1'b0;
                flush      = golden[base][9];
                exp_valid  = 1'b1;
                exp_bubble = golden[base][9];
                exp_idx    = r;
                for (int w = 0; w < 6; w++) begin
                    exp_words[w] = golden[base+2+(w == 0 ? 0 : w+2)];
                end
            end
        end
        next_cycle();
        exp_valid = 1'b0;
        stall     = 1'b1;
        flush     = 1'b0;
        wait (checked == n_decode);
        @(posedge clk_i);
        total_errors = errors + decode_stage_i.decode_properties_i.fail_count;
        $display("checked %0d records, %0d errors", checked, total_errors);
        if (total_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* tests/decode_golden.mem */
// w0 {flush[9],stall[8],fwd2[7:6],fwd1[5:4],type[3:0]} type 1 write: w1 addr w2 data
// decode: w1 inst w2 pc w3 wb w4 ex w5 val1 w6 val2 w7 imm w8 {ctrl,uop,unit,rd} w9 {cmp,exc}
00000001 00000001 00000005 0 0 0 0 0 0 0
00000001 00000002 FFFFFFF0 0 0 0 0 0 0 0
00000001 00000003 00000005 0 0 0 0 0 0 0
00000001 00000005 12345678 0 0 0 0 0 0 0
00000001 00000000 DEADBEEF 0 0 0 0 0 0 0
00000002 00208233 00000100 00000000 00000000 00000005 FFFFFFF0 00000000 80010004 00000020
00000062 40110333 00000104 7FFFFFFF 80000000 80000000 7FFFFFFF 00000000 80020006 00000040
00000002 FFD08393 00000108 00000000 00000000 00000005 FFFFFFFD FFFFFFFD 82010007 00000000
00000102 00C2A403 0000010C 00000000 00000000 12345678 0000000C 0000000C D20D0108 00000000
00000002 FE30AC23 00000110 00000000 00000000 00000005 FFFFFFF8 FFFFFFF8 22120118 00000010
00000002 FE1148E3 00000114 00000000 00000000 00000114 FFFFFFF0 FFFFFFF0 09150211 00000040
00000002 010000EF 00000118 00000000 00000000 00000000 00000000 00000010 84190201 00000010
00000002 00428067 0000011C 00000000 00000000 0000011C 00000004 00000004 851A0200 00000000
00000002 ABCDE4B7 00000120 00000000 00000000 00000000 00000000 ABCDE000 80010009 00000010
00000002 00001517 00000124 00000000 00000000 00000000 00000000 00001000 8001000A 00000010
00000002 FFFFFFFF 00000128 00000000 00000000 00000000 00000000 00000000 0000001F 00000011
00000002 02309593 0000012C 00000000 00000000 00000005 00000005 00000023 0000000B 00000011
00000002 00000073 00000130 00000000 00000000 00000000 00000000 00000000 82000300 00000012
00000002 00100073 00000134 00000000 00000000 00000000 00000001 00000001 82000300 00000064
00000002 30200073 00000138 00000000 00000000 00000000 00000302 00000302 82000300 00000028
00000202 00208233 0000013C 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000002 00000633 00000140 00000000 00000000 00000000 00000000 00000000 8001000C 00000010
00000000 0 0 0 0 0 0 0 0 0

/* flist.f */
rtl/decode_pkg.sv
rtl/decode_if.sv
rtl/inst_decoder.sv
rtl/imm_gen.sv
rtl/reg_file.sv
rtl/operand_select.sv
rtl/id_ex_reg.sv
rtl/decode_stage.sv
tests/decode_properties.sv
tests/decode_checker.sv
tests/tb_decode_stage.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - rtl/decode_pkg.sv
      - rtl/decode_if.sv
      - rtl/inst_decoder.sv
      - rtl/imm_gen.sv
      - rtl/reg_file.sv
      - rtl/operand_select.sv
      - rtl/id_ex_reg.sv
      - rtl/decode_stage.sv
  - target: test
    files:
      - tests/decode_properties.sv
      - tests/decode_checker.sv
      - tests/tb_decode_stage.sv
